//--- hw/pcpu_bus_pkg.sv
// peripheral bus definitions
// address map, bus widths and decoded target regions of the
// request/ready bus behind the CPU
`default_nettype none

package pcpu_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // region select uses address bits above this one
    localparam int REGION_LSB = 24;

    localparam logic [ADDR_W-1:0] RAM_BASE   = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] GPIO_BASE  = 32'h9000_0000;
    localparam logic [ADDR_W-1:0] TIMER_BASE = 32'h9100_0000;
    localparam logic [ADDR_W-1:0] INT_BASE   = 32'h9200_0000;

    typedef enum logic [2:0] {
        REG_RAM,
        REG_GPIO,
        REG_TIMER,
        REG_INT,
        REG_NONE
    } region_t;

endpackage

`default_nettype wire

//--- hw/pcpu_irq_pkg.sv
// interrupt definitions
// source bit positions and register word offsets of the interrupt unit
`default_nettype none

package pcpu_irq_pkg;

    typedef enum logic [1:0] {
        IRQ_TIMER = 2'd0,
        IRQ_GPIO  = 2'd1,
        IRQ_FAULT = 2'd2
    } irq_src_t;

    localparam int IRQ_NUM = 3;

    // word offsets inside the interrupt region
    localparam int INT_PENDING = 0;
    localparam int INT_ENABLE  = 1;

endpackage

`default_nettype wire

//--- hw/mem_bus_if.sv
// memory bus interface
// one request/ready bus, address, write data, strobes, read data, ready
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    import pcpu_bus_pkg::*;

    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic              we;
    logic              rd;
    logic [DATA_W-1:0] spo;
    logic              ready;

    // requester side
    modport master (
        output a, d, we, rd,
        input  spo, ready
    );

    // responder side
    modport slave (
        input  a, d, we, rd,
        output spo, ready
    );

endinterface

`default_nettype wire

//--- hw/mmapper.sv
// memory mapper
// decodes the master address into one of four targets, passes the
// word offset and strobes to that target and returns its response;
// unmapped or out-of-range accesses answer at once with zero and
// raise a fault pulse
`timescale 1ns/1ps
`default_nettype none

module mmapper #(
    parameter int RAM_DEPTH = 12
) (
    input  logic      clk,
    input  logic      rst_n,
    mem_bus_if.slave  cpu,
    mem_bus_if.master ram,
    mem_bus_if.master gpio,
    mem_bus_if.master tmr,
    mem_bus_if.master intc,
    output logic      fault
);
    import pcpu_bus_pkg::*;

    region_t           region;
    logic              req;
    logic [ADDR_W-1:0] word_off;

    assign req = cpu.we || cpu.rd;

    // ram is matched on every bit above its word index
    always_comb begin
        region = REG_NONE;
        if (cpu.a[ADDR_W-1:RAM_DEPTH+2] == RAM_BASE[ADDR_W-1:RAM_DEPTH+2]) begin
            region = REG_RAM;
        end else if (cpu.a[ADDR_W-1:REGION_LSB] == GPIO_BASE[ADDR_W-1:REGION_LSB]) begin
            region = REG_GPIO;
        end else if (cpu.a[ADDR_W-1:REGION_LSB] == TIMER_BASE[ADDR_W-1:REGION_LSB]) begin
            region = REG_TIMER;
        end else if (cpu.a[ADDR_W-1:REGION_LSB] == INT_BASE[ADDR_W-1:REGION_LSB]) begin
            region = REG_INT;
        end
    end

    always_comb begin
        word_off = '0;
        word_off[REGION_LSB-3:0] = cpu.a[REGION_LSB-1:2];
    end

    assign ram.a   = word_off;
    assign ram.d   = cpu.d;
    assign ram.we  = cpu.we && (region == REG_RAM);
    assign ram.rd  = cpu.rd && (region == REG_RAM);

    assign gpio.a  = word_off;
    assign gpio.d  = cpu.d;
    assign gpio.we = cpu.we && (region == REG_GPIO);
    assign gpio.rd = cpu.rd && (region == REG_GPIO);

    assign tmr.a   = word_off;
    assign tmr.d   = cpu.d;
    assign tmr.we  = cpu.we && (region == REG_TIMER);
    assign tmr.rd  = cpu.rd && (region == REG_TIMER);

    assign intc.a  = word_off;
    assign intc.d  = cpu.d;
    assign intc.we = cpu.we && (region == REG_INT);
    assign intc.rd = cpu.rd && (region == REG_INT);

    // response mux
    always_comb begin
        cpu.spo   = '0;
        cpu.ready = 1'b0;
        case (region)
            REG_RAM: begin
                cpu.spo   = ram.spo;
                cpu.ready = ram.ready;
            end
            REG_GPIO: begin
                cpu.spo   = gpio.spo;
                cpu.ready = gpio.ready;
            end
            REG_TIMER: begin
                cpu.spo   = tmr.spo;
                cpu.ready = tmr.ready;
            end
            REG_INT: begin
                cpu.spo   = intc.spo;
                cpu.ready = intc.ready;
            end
            default: begin
                // nobody home, finish the transfer right away
                cpu.ready = req;
            end
        endcase
    end

    assign fault = req && (region == REG_NONE);

    // a single strobe reaches a single target
    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram.we, ram.rd, gpio.we, gpio.rd, tmr.we, tmr.rd, intc.we, intc.rd}));

endmodule

`default_nettype wire

//--- hw/simple_ram.sv
// data RAM
// word array with registered read data; ready follows one cycle
// after the request starts and lasts a single cycle
`timescale 1ns/1ps
`default_nettype none

module simple_ram #(
    parameter int RAM_DEPTH = 12
) (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus
);
    import pcpu_bus_pkg::*;

    logic [DATA_W-1:0]    mem [2**RAM_DEPTH];
    logic [DATA_W-1:0]    rdata;
    logic [RAM_DEPTH-1:0] idx;
    logic                 busy;

    assign idx = bus.a[RAM_DEPTH-1:0];

    // busy marks the response cycle of the held request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= (bus.we || bus.rd) && !busy;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rd && !busy) begin
            rdata <= mem[idx];
        end
        // write completes on the ready edge
        if (bus.we && busy) begin
            mem[idx] <= bus.d;
        end
    end

    assign bus.ready = busy;
    assign bus.spo   = rdata;

    // response only while the request is held, never twice in a row
    a_single_ready: assert property (@(posedge clk) disable iff (!rst_n)
        bus.ready |-> (bus.we || bus.rd) ##1 !bus.ready);

endmodule

`default_nettype wire

//--- hw/timer.sv
// programmable timer
// down-counter reloaded from a period register; pulses tick_irq
// each time it wraps, so a period P gives one pulse every P+1 cycles
`timescale 1ns/1ps
`default_nettype none

module timer #(
    parameter int TIMER_COUNTER = 1000
) (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus,
    output logic     tick_irq
);
    import pcpu_bus_pkg::*;

    localparam int W_PERIOD = 0;
    localparam int W_COUNT  = 1;

    logic [DATA_W-1:0] period;
    logic [DATA_W-1:0] count;
    logic              wr_period;

    assign wr_period = bus.we && (bus.a == W_PERIOD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period   <= DATA_W'(TIMER_COUNTER);
            count    <= DATA_W'(TIMER_COUNTER);
            tick_irq <= 1'b0;
        end else begin
            tick_irq <= 1'b0;
            if (wr_period) begin
                // new period restarts the count
                period <= bus.d;
                count  <= bus.d;
            end else if (count == '0) begin
                count    <= period;
                tick_irq <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    always_comb begin
        bus.spo = '0;
        if (bus.a == W_PERIOD) begin
            bus.spo = period;
        end else if (bus.a == W_COUNT) begin
            bus.spo = count;
        end
    end

    assign bus.ready = bus.we || bus.rd;

endmodule

`default_nettype wire

//--- hw/interrupt_unit.sv
// interrupt unit
// collects timer, button and bus-fault pulses into pending bits,
// masks them with the enable register and drives one registered
// interrupt line toward the CPU
`timescale 1ns/1ps
`default_nettype none

module interrupt_unit (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus,
    input  logic     tick_irq,
    input  logic     btn_irq,
    input  logic     fault,
    output logic     irq
);
    import pcpu_bus_pkg::*;
    import pcpu_irq_pkg::*;

    logic [IRQ_NUM-1:0] pending;
    logic [IRQ_NUM-1:0] enable;
    logic [IRQ_NUM-1:0] src;
    logic [IRQ_NUM-1:0] clr;

    assign src[IRQ_TIMER] = tick_irq;
    assign src[IRQ_GPIO]  = btn_irq;
    assign src[IRQ_FAULT] = fault;

    // write one to clear
    assign clr = (bus.we && bus.a == INT_PENDING) ? bus.d[IRQ_NUM-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
            enable  <= '0;
            irq     <= 1'b0;
        end else begin
            // a new pulse wins over a clear
            pending <= (pending & ~clr) | src;
            if (bus.we && bus.a == INT_ENABLE) begin
                enable <= bus.d[IRQ_NUM-1:0];
            end
            irq <= |(pending & enable);
        end
    end

    always_comb begin
        bus.spo = '0;
        if (bus.a == INT_PENDING) begin
            bus.spo[IRQ_NUM-1:0] = pending;
        end else if (bus.a == INT_ENABLE) begin
            bus.spo[IRQ_NUM-1:0] = enable;
        end
    end

    assign bus.ready = bus.we || bus.rd;

endmodule

`default_nettype wire

//--- hw/gpio.sv
// GPIO block
// LED output register, synchronized button read-back and a
// one-cycle interrupt on any button rising edge
`timescale 1ns/1ps
`default_nettype none

module gpio #(
    parameter int N_BTN = 2,
    parameter int N_LED = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    mem_bus_if.slave         bus,
    input  logic [N_BTN-1:0] btn,
    output logic [N_LED-1:0] led,
    output logic             btn_irq
);
    import pcpu_bus_pkg::*;

    localparam int W_LED = 0;
    localparam int W_BTN = 1;

    logic [N_BTN-1:0] btn_meta;
    logic [N_BTN-1:0] btn_sync;
    logic [N_BTN-1:0] btn_prev;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
            btn_irq  <= 1'b0;
            led      <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            btn_irq  <= |(btn_sync & ~btn_prev);
            if (bus.we && bus.a == W_LED) begin
                led <= bus.d[N_LED-1:0];
            end
        end
    end

    always_comb begin
        bus.spo = '0;
        if (bus.a == W_LED) begin
            bus.spo[N_LED-1:0] = led;
        end else if (bus.a == W_BTN) begin
            bus.spo[N_BTN-1:0] = btn_sync;
        end
    end

    assign bus.ready = bus.we || bus.rd;

endmodule

`default_nettype wire

//--- hw/pcpu_periph_top.sv
// peripheral subsystem top
// address mapper in front of data RAM, GPIO, timer and interrupt unit
`timescale 1ns/1ps
`default_nettype none

module pcpu_periph_top #(
    parameter int RAM_DEPTH     = 12,
    parameter int TIMER_COUNTER = 1000,
    parameter int N_BTN         = 2,
    parameter int N_LED         = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [pcpu_bus_pkg::ADDR_W-1:0] a,
    input  logic [pcpu_bus_pkg::DATA_W-1:0] d,
    input  logic                            we,
    input  logic                            rd,
    output logic [pcpu_bus_pkg::DATA_W-1:0] spo,
    output logic                            ready,
    input  logic [N_BTN-1:0]                btn,
    output logic [N_LED-1:0]                led,
    output logic                            irq
);

    mem_bus_if cpu_bus ();
    mem_bus_if ram_bus ();
    mem_bus_if gpio_bus ();
    mem_bus_if tmr_bus ();
    mem_bus_if int_bus ();

    logic tick_irq;
    logic btn_irq;
    logic fault;

    assign cpu_bus.a  = a;
    assign cpu_bus.d  = d;
    assign cpu_bus.we = we;
    assign cpu_bus.rd = rd;
    assign spo        = cpu_bus.spo;
    assign ready      = cpu_bus.ready;

    mmapper #(.RAM_DEPTH(RAM_DEPTH)) mmapper_inst (
        .clk(clk), .rst_n(rst_n), .cpu(cpu_bus.slave),
        .ram(ram_bus.master), .gpio(gpio_bus.master),
        .tmr(tmr_bus.master), .intc(int_bus.master), .fault(fault)
    );

    simple_ram #(.RAM_DEPTH(RAM_DEPTH)) ram_inst (
        .clk(clk), .rst_n(rst_n), .bus(ram_bus.slave)
    );

    gpio #(.N_BTN(N_BTN), .N_LED(N_LED)) gpio_inst (
        .clk(clk), .rst_n(rst_n), .bus(gpio_bus.slave),
        .btn(btn), .led(led), .btn_irq(btn_irq)
    );

    timer #(.TIMER_COUNTER(TIMER_COUNTER)) timer_inst (
        .clk(clk), .rst_n(rst_n), .bus(tmr_bus.slave), .tick_irq(tick_irq)
    );

    interrupt_unit interrupt_unit_inst (
        .clk(clk), .rst_n(rst_n), .bus(int_bus.slave),
        .tick_irq(tick_irq), .btn_irq(btn_irq), .fault(fault), .irq(irq)
    );

endmodule

`default_nettype wire

//--- verification/tb_pcpu_periph.sv
// testbench for the peripheral subsystem
// builds a table of bus accesses, button changes and irq checks,
// applies it through the request/ready port and compares results
// against values derived from the address map and register rules
`timescale 1ns/1ps
`default_nettype none

module tb_pcpu_periph;
    import pcpu_bus_pkg::*;
    import pcpu_irq_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RAM_DEPTH     = 12;
    localparam int TIMER_COUNTER = 50;
    localparam int MAX_ENTRIES   = 64;
    localparam int POLL_CYCLES   = 25;

    localparam logic [31:0] A_LED    = GPIO_BASE;
    localparam logic [31:0] A_BTN    = GPIO_BASE + 32'd4;
    localparam logic [31:0] A_PERIOD = TIMER_BASE;
    localparam logic [31:0] A_PEND   = INT_BASE + 32'(4 * INT_PENDING);
    localparam logic [31:0] A_EN     = INT_BASE + 32'(4 * INT_ENABLE);
    localparam logic [31:0] M_TMR    = 32'd1 << IRQ_TIMER;
    localparam logic [31:0] M_BTN    = 32'd1 << IRQ_GPIO;
    localparam logic [31:0] M_FAULT  = 32'd1 << IRQ_FAULT;

    typedef enum {OP_WRITE, OP_READ, OP_POLL, OP_BTN, OP_LED, OP_IRQ} op_t;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic              we;
    logic              rd;
    logic [DATA_W-1:0] spo;
    logic              ready;
    logic [1:0]        btn;
    logic [3:0]        led;
    logic              irq;

    // for reads and polls the data column holds the compare mask
    op_t         t_op   [MAX_ENTRIES];
    logic [31:0] t_addr [MAX_ENTRIES];
    logic [31:0] t_data [MAX_ENTRIES];
    logic [1:0]  t_btn  [MAX_ENTRIES];
    logic [31:0] t_exp  [MAX_ENTRIES];
    int          n_entries = 0;
    logic        table_built = 1'b0;
    int          cycle_cnt = 0;
    integer      seed;

    pcpu_periph_top #(
        .RAM_DEPTH(RAM_DEPTH),
        .TIMER_COUNTER(TIMER_COUNTER)
    ) DUT (
        .clk(clk), .rst_n(rst_n), .a(a), .d(d), .we(we), .rd(rd),
        .spo(spo), .ready(ready), .btn(btn), .led(led), .irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add(input op_t op, input logic [31:0] addr, input logic [31:0] data,
                       input logic [1:0] b, input logic [31:0] exp);
        t_op[n_entries]   = op;
        t_addr[n_entries] = addr;
        t_data[n_entries] = data;
        t_btn[n_entries]  = b;
        t_exp[n_entries]  = exp;
        n_entries++;
    endtask

    // RAM answers one cycle late, every register block at once
    function automatic int read_latency(input logic [31:0] addr);
        return (addr[31:24] == RAM_BASE[31:24]) ? 1 : 0;
    endfunction

    task automatic bus_xfer(input logic is_wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int lat);
        lat = 0;
        @(negedge clk);
        a  = addr;
        d  = wdata;
        we = is_wr;
        rd = !is_wr;
        // ready sampled a quarter cycle after the falling edge
        #1;
        while (!ready) begin
            @(negedge clk);
            #1;
            lat++;
        end
        rdata = spo;
        @(posedge clk);
        @(negedge clk);
        we = 1'b0;
        rd = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        int          lat;
        bus_xfer(1'b1, addr, wdata, unused, lat);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                            output int lat);
        bus_xfer(1'b0, addr, 32'h0, rdata, lat);
    endtask

    task automatic build_table();
        logic [31:0] ram_addr [8];
        logic [31:0] ram_word [8];
        int          seg;
        int          idx;
        seg = (2 ** RAM_DEPTH) / 8;
        // first word, last word and one word in each inner segment
        for (int k = 0; k < 8; k++) begin
            if (k == 0) idx = 0;
            else if (k == 7) idx = 2 ** RAM_DEPTH - 1;
            else idx = k * seg + ($random(seed) & (seg - 1));
            ram_addr[k] = RAM_BASE + 32'(idx * 4);
            ram_word[k] = $random(seed);
            add(OP_WRITE, ram_addr[k], ram_word[k], 2'b00, 32'h0);
        end
        for (int k = 0; k < 8; k++) begin
            add(OP_READ, ram_addr[k], 32'hffff_ffff, 2'b00, ram_word[k]);
        end
        // button edge while every enable is still zero
        add(OP_BTN, 32'h0, 32'h0, 2'b01, 32'h0);
        add(OP_READ, A_BTN, 32'h3, 2'b00, 32'h1);
        add(OP_READ, A_PEND, M_BTN, 2'b00, M_BTN);
        add(OP_IRQ, 32'h0, 32'h0, 2'b00, 32'h0);
        add(OP_WRITE, A_EN, M_BTN, 2'b00, 32'h0);
        add(OP_IRQ, 32'h0, 32'h0, 2'b00, 32'h1);
        add(OP_WRITE, A_LED, 32'ha, 2'b00, 32'h0);
        add(OP_LED, 32'h0, 32'h0, 2'b00, 32'ha);
        add(OP_READ, A_LED, 32'hf, 2'b00, 32'ha);
        // timer at period 20
        add(OP_WRITE, A_EN, 32'h0, 2'b00, 32'h0);
        add(OP_WRITE, A_PERIOD, 32'd20, 2'b00, 32'h0);
        add(OP_WRITE, A_EN, M_TMR, 2'b00, 32'h0);
        add(OP_WRITE, A_PEND, 32'h7, 2'b00, 32'h0);
        add(OP_POLL, A_PEND, M_TMR, 2'b00, M_TMR);
        add(OP_IRQ, 32'h0, 32'h0, 2'b00, 32'h1);
        add(OP_READ, A_PERIOD, 32'hffff_ffff, 2'b00, 32'd20);
        // slow the timer down so the clear sticks
        add(OP_WRITE, A_PERIOD, 32'd1000, 2'b00, 32'h0);
        add(OP_WRITE, A_PEND, M_TMR, 2'b00, 32'h0);
        add(OP_READ, A_PEND, M_TMR, 2'b00, 32'h0);
        add(OP_IRQ, 32'h0, 32'h0, 2'b00, 32'h0);
        // unmapped access
        add(OP_READ, 32'h8000_0000, 32'hffff_ffff, 2'b00, 32'h0);
        add(OP_READ, A_PEND, M_FAULT, 2'b00, M_FAULT);
    endtask

    initial begin : watchdog
        int limit;
        wait (table_built);
        limit = n_entries * 200 + 20 * (TIMER_COUNTER + 1);
        repeat (limit) @(posedge clk);
        $display("timeout: the run hung and did not finish within %0d cycles", limit);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] rdata;
        int          lat;
        int          start;
        a     = '0;
        d     = '0;
        we    = 1'b0;
        rd    = 1'b0;
        btn   = '0;
        rst_n = 1'b0;
        seed  = 32'h7c889b3e;
        build_table();
        table_built = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_entries; i++) begin
            case (t_op[i])
                OP_WRITE: bus_write(t_addr[i], t_data[i]);
                OP_READ: begin
                    bus_read(t_addr[i], rdata, lat);
                    check(rdata & t_data[i], t_exp[i], $sformatf("entry %0d read data", i));
                    check(32'(lat), 32'(read_latency(t_addr[i])),
                          $sformatf("entry %0d ready latency", i));
                end
                OP_POLL: begin
                    start = cycle_cnt;
                    do begin
                        bus_read(t_addr[i], rdata, lat);
                    end while (((rdata & t_data[i]) != t_exp[i])
                               && (cycle_cnt - start <= POLL_CYCLES));
                    check(rdata & t_data[i], t_exp[i], $sformatf("entry %0d poll", i));
                end
                OP_BTN: begin
                    @(negedge clk);
                    btn = t_btn[i];
                    // synchronizer settles within three cycles
                    repeat (3) @(negedge clk);
                end
                OP_LED: begin
                    @(negedge clk);
                    check(32'(led), t_exp[i], $sformatf("entry %0d led", i));
                end
                default: begin
                    repeat (2) @(negedge clk);
                    check(32'(irq), t_exp[i], $sformatf("entry %0d irq", i));
                end
            endcase
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- pcpu_periph_top.f
hw/pcpu_bus_pkg.sv
hw/pcpu_irq_pkg.sv
hw/mem_bus_if.sv
hw/mmapper.sv
hw/simple_ram.sv
hw/timer.sv
hw/interrupt_unit.sv
hw/gpio.sv
hw/pcpu_periph_top.sv
verification/tb_pcpu_periph.sv

//--- Bender.yml
package:
  name: pcpu_periph

sources:
  - hw/pcpu_bus_pkg.sv
  - hw/pcpu_irq_pkg.sv
  - hw/mem_bus_if.sv
  - hw/mmapper.sv
  - hw/simple_ram.sv
  - hw/timer.sv
  - hw/interrupt_unit.sv
  - hw/gpio.sv
  - hw/pcpu_periph_top.sv
  - target: simulation
    files:
      - verification/tb_pcpu_periph.sv
